//--- tb/rom_patterns.txt
# name  header bytes 0..15 (hex)  extra_words  exp_mapper_flags (hex)  exp_error
# Payload follows the header, PRG pages x 16384 then CHR pages x 8192 bytes
# Plain header, one PRG and one CHR page, mapper 1 with mirroring
basic      4E 45 53 1A 01 01 11 00 00 00 00 00 00 00 00 00 0 00004001 0
# No CHR ROM so chr_ram, three PRG pages, four-screen, mapper 0x20
chr_ram    4E 45 53 1A 03 00 08 20 00 00 00 00 00 00 00 00 2 00018220 0
# Junk in byte 12 clears the upper mapper nibble
dirty      4E 45 53 1A 01 02 40 30 00 00 00 00 55 00 00 00 0 00000804 0
# iNES 2.0 with extension byte, tail bytes allowed
nes20      4E 45 53 1A 01 01 01 18 25 00 07 00 00 00 00 00 1 004A4010 0
# Rejected headers, no writes expected
bad_magic  4E 45 53 1B 01 01 00 00 00 00 00 00 00 00 00 00 1 00000000 1
trainer    4E 45 53 1A 01 01 04 00 00 00 00 00 00 00 00 00 0 00000000 1

//--- verilog.f
source/loader_pkg.sv
source/boot_word_intake.sv
source/word_fifo.sv
source/byte_pacer.sv
source/ines_header_decode.sv
source/ines_loader.sv
source/rom_loader_top.sv
tb/tb_rom_loader.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ROM loader testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_rom_loader \
	-f verilog.f -o tb_sim || { echo "Verilator build failed"; exit 1; }
result=$(./obj_dir/tb_sim 2>&1)
echo "$result"
echo "$result" | grep -q "^NO ERRORS$" && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- tb/tb_rom_loader.sv
//--------------------------------------
// ROM loader testbench driving header cases
// and expected flags read from rom_patterns.txt
//--------------------------------------
`timescale 1ns/10ps

module tb_rom_loader;

	localparam int MARGIN = 5000; // Slack cycles for handshakes and drains

	logic                          clk;
	logic                          host_reset_loader;
	logic [loader_pkg::WORD_W-1:0] bootdata;
	logic                          bootdata_req;
	logic                          bootdata_ack;
	loader_pkg::mem_wr_t           mem_wr;
	logic                          mem_write;
	loader_pkg::mapper_flags_t     mapper_flags;
	logic                          done;
	logic                          error;

	// Pattern table with one entry per file line
	string               names[$];
	logic [15:0][7:0]    headers[$];
	int                  extras[$];
	logic [31:0]         exp_flags[$];
	logic                exp_errs[$];

	loader_pkg::mem_wr_t           exp_q[$]; // Writes still owed
	logic [loader_pkg::WORD_W-1:0] words[$]; // Boot stream of one test
	string                         cur_name;
	logic                          cur_err;
	int                            cycle;
	int                            limit;
	int                            last_write_cycle;
	logic                          done_seen;

	rom_loader_top DUT (
		.clk               (clk),
		.host_reset_loader (host_reset_loader),
		.bootdata_i        (bootdata),
		.bootdata_req_i    (bootdata_req),
		.bootdata_ack_o    (bootdata_ack),
		.mem_wr_o          (mem_wr),
		.mem_write_o       (mem_write),
		.mapper_flags_o    (mapper_flags),
		.done_o            (done),
		.error_o           (error)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
			abort_run($sformatf("mismatch %s %s: expected %0h actual %0h",
				cur_name, what, expected, actual));
	endtask

	// Cycle counter that doubles as the watchdog
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if ((limit > 0) && (cycle >= limit))
			abort_run($sformatf("timeout: test %s still running after %0d cycles",
				cur_name, limit));
	end

	//--------------------------------------
	// Write monitor sampled mid cycle
	//--------------------------------------
	always @(negedge clk) begin
		loader_pkg::mem_wr_t want;
		if (!host_reset_loader) begin
			if (mem_write) begin
				if (exp_q.size() == 0) begin
					abort_run($sformatf("test %s wrote address %0h with no write expected",
						cur_name, mem_wr.addr));
				end else begin
					want = exp_q.pop_front();
					check_value("write address", want.addr, mem_wr.addr);
					check_value("write data", want.data, mem_wr.data);
					last_write_cycle = cycle;
				end
			end
			if (done && !done_seen) begin
				done_seen = 1'b1;
				if (!cur_err && (last_write_cycle >= 0))
					check_value("done delay", 1, cycle - last_write_cycle); // One after last write
			end
		end
	end

	task automatic read_patterns(input int fd);
		string       line;
		string       name;
		logic [7:0]  hb[16];
		logic [15:0][7:0] hdr;
		int          extra;
		logic [31:0] flags;
		int          err;
		int          n;
		while ($fgets(line, fd) != 0) begin
			n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d %h %d",
				name, hb[0], hb[1], hb[2], hb[3], hb[4], hb[5], hb[6], hb[7], hb[8], hb[9],
				hb[10], hb[11], hb[12], hb[13], hb[14], hb[15], extra, flags, err);
			if (n == 20) begin // Comment and blank lines fall through
				for (int k = 0; k < 16; k++)
					hdr[k] = hb[k];
				names.push_back(name);
				headers.push_back(hdr);
				extras.push_back(extra);
				exp_flags.push_back(flags);
				exp_errs.push_back(err[0]);
			end
		end
		$fclose(fd);
	endtask

	// One host request per word with req dropped the cycle after ack
	task automatic send_word(input logic [loader_pkg::WORD_W-1:0] w);
		@(posedge clk);
		bootdata     <= w;
		bootdata_req <= 1'b1;
		do @(negedge clk); while (!bootdata_ack); // Held while FIFO full
		@(posedge clk);
		bootdata_req <= 1'b0;
	endtask

	function automatic int payload_bytes(input logic [15:0][7:0] hdr, input logic err);
		if (err)
			return 0;
		return (int'(hdr[4]) << 14) + (int'(hdr[5]) << 13); // 16 KiB PRG, 8 KiB CHR pages
	endfunction

	task automatic run_test(input int idx);
		logic [15:0][7:0]              hdr;
		int                            payload;
		int                            prg_bytes;
		int                            drain;
		logic [7:0]                    b;
		logic [loader_pkg::WORD_W-1:0] w;
		loader_pkg::mem_wr_t           exp_wr;
		hdr       = headers[idx];
		cur_name  = names[idx];
		cur_err   = exp_errs[idx];
		payload   = payload_bytes(hdr, cur_err);
		prg_bytes = int'(hdr[4]) << 14;
		exp_q.delete();
		words.delete();
		for (int i = 0; i < 4; i++)
			words.push_back(hdr[i*4 +: 4]); // Little endian header words
		w = '0;
		for (int i = 0; i < payload + 4 * extras[idx]; i++) begin
			b = 8'($urandom);
			w[(i % 4)*8 +: 8] = b;
			if (i < payload) begin
				exp_wr.data = b;
				if (i < prg_bytes)
					exp_wr.addr = loader_pkg::PRG_BASE + i[loader_pkg::ADDR_W-1:0];
				else
					exp_wr.addr = loader_pkg::CHR_BASE + (i - prg_bytes);
				exp_q.push_back(exp_wr);
			end
			if ((i % 4) == 3)
				words.push_back(w);
		end
		// Two cycles of reset
		@(posedge clk);
		host_reset_loader <= 1'b1;
		repeat (2) @(posedge clk);
		done_seen        = 1'b0; // Done of the last test already cleared
		last_write_cycle = -1;
		host_reset_loader <= 1'b0;
		foreach (words[k])
			send_word(words[k]);
		do @(negedge clk); while (!done);
		check_value("error", cur_err, error);
		check_value("mapper flags", exp_flags[idx], mapper_flags);
		check_value("writes left", 0, exp_q.size());
		// Trailing words drain with no writes
		drain = (loader_pkg::FIFO_DEPTH + extras[idx] + 2) * 4 * loader_pkg::BYTE_PERIOD;
		repeat (drain) @(negedge clk);
		check_value("done held", 1, done);
		$display("test %s finished", cur_name);
	endtask

	//--------------------------------------
	// Main sequence
	//--------------------------------------
	initial begin
		int fd;
		int total;
		host_reset_loader = 1'b1;
		bootdata_req      = 1'b0;
		bootdata          = '0;
		total             = 0;
		void'($urandom(32'h1f5a));
		fd = $fopen("tb/rom_patterns.txt", "r");
		if (fd == 0)
			abort_run("could not open the pattern file tb/rom_patterns.txt");
		else
			read_patterns(fd);
		for (int t = 0; t < names.size(); t++)
			total += 16 + payload_bytes(headers[t], exp_errs[t]) + 4 * extras[t];
		limit = total * loader_pkg::BYTE_PERIOD * 2 + MARGIN;
		for (int t = 0; t < names.size(); t++)
			run_test(t);
		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- source/rom_loader_top.sv
//--------------------------------------
// ROM loading path top level
//--------------------------------------
`timescale 1ns/10ps

module rom_loader_top (
	input  logic                          clk,
	input  logic                          host_reset_loader,
	input  logic [loader_pkg::WORD_W-1:0] bootdata_i,
	input  logic                          bootdata_req_i,
	output logic                          bootdata_ack_o,
	output loader_pkg::mem_wr_t           mem_wr_o,
	output logic                          mem_write_o,
	output loader_pkg::mapper_flags_t     mapper_flags_o,
	output logic                          done_o,
	output logic                          error_o
);

	logic                          push;
	logic [loader_pkg::WORD_W-1:0] push_word;
	logic                          fifo_full;
	logic                          fifo_empty;
	logic [loader_pkg::WORD_W-1:0] head_word;
	logic                          pop;
	logic [7:0]                    load_byte;
	logic                          load_stb;

	// Host side
	boot_word_intake u_intake (
		.clk               (clk),
		.host_reset_loader (host_reset_loader),
		.bootdata_i        (bootdata_i),
		.bootdata_req_i    (bootdata_req_i),
		.fifo_full_i       (fifo_full),
		.bootdata_ack_o    (bootdata_ack_o),
		.push_o            (push),
		.push_word_o       (push_word)
	);

	word_fifo u_fifo (
		.clk               (clk),
		.host_reset_loader (host_reset_loader),
		.push_i            (push),
		.word_i            (push_word),
		.pop_i             (pop),
		.word_o            (head_word),
		.full_o            (fifo_full),
		.empty_o           (fifo_empty)
	);

	byte_pacer u_pacer (
		.clk               (clk),
		.host_reset_loader (host_reset_loader),
		.word_i            (head_word),
		.empty_i           (fifo_empty),
		.pop_o             (pop),
		.byte_o            (load_byte),
		.byte_stb_o        (load_stb)
	);

	// Memory side
	ines_loader u_loader (
		.clk               (clk),
		.host_reset_loader (host_reset_loader),
		.byte_i            (load_byte),
		.byte_stb_i        (load_stb),
		.mem_wr_o          (mem_wr_o),
		.mem_write_o       (mem_write_o),
		.mapper_flags_o    (mapper_flags_o),
		.done_o            (done_o),
		.error_o           (error_o)
	);

endmodule

//--- source/ines_loader.sv
//--------------------------------------
// iNES byte stream loader that captures
// the header and writes PRG then CHR
//--------------------------------------
`timescale 1ns/10ps

module ines_loader (
	input  logic                      clk,
	input  logic                      host_reset_loader,
	input  logic [7:0]                byte_i,
	input  logic                      byte_stb_i,
	output loader_pkg::mem_wr_t       mem_wr_o,
	output logic                      mem_write_o,
	output loader_pkg::mapper_flags_t mapper_flags_o,
	output logic                      done_o,
	output logic                      error_o
);

	loader_pkg::load_state_e         state;
	logic [15:0][7:0]                hdr;        // Raw header bytes
	logic [3:0]                      hdr_cnt;
	logic [loader_pkg::ADDR_W-1:0]   wr_addr;
	logic [loader_pkg::ADDR_W-1:0]   bytes_left;
	logic [loader_pkg::ADDR_W-1:0]   prg_bytes;
	logic [loader_pkg::ADDR_W-1:0]   chr_bytes;
	logic                            hdr_ok;
	logic                            in_payload;
	loader_pkg::ines_fields_t        fields;
	loader_pkg::mapper_flags_t       flags;

	assign prg_bytes  = hdr[4] << loader_pkg::PRG_PAGE_SHIFT; // Pages to bytes
	assign chr_bytes  = hdr[5] << loader_pkg::CHR_PAGE_SHIFT;
	// Magic plus no trainer
	assign hdr_ok     = (hdr[3:0] == loader_pkg::INES_MAGIC) && !hdr[6][2];
	assign in_payload = (state == loader_pkg::LD_PRG) || (state == loader_pkg::LD_CHR);
	assign fields     = loader_pkg::ines_fields_t'(hdr[15:4]);

	ines_header_decode u_decode (
		.fields_i (fields),
		.flags_o  (flags)
	);

	//--------------------------------------
	// Header bytes and write payload
	//--------------------------------------
	always_ff @(posedge clk) begin
		if (byte_stb_i && (state == loader_pkg::LD_HEADER))
			hdr[hdr_cnt] <= byte_i;
		if (byte_stb_i && in_payload) begin
			mem_wr_o.addr <= wr_addr;
			mem_wr_o.data <= byte_i;
		end
	end

	//--------------------------------------
	// Sequencing
	//--------------------------------------
	always_ff @(posedge clk) begin
		if (host_reset_loader) begin
			state          <= loader_pkg::LD_HEADER;
			hdr_cnt        <= '0;
			wr_addr        <= '0;
			bytes_left     <= '0;
			mem_write_o    <= 1'b0;
			mapper_flags_o <= '0;
			done_o         <= 1'b0;
			error_o        <= 1'b0;
		end else begin
			mem_write_o <= 1'b0;
			case (state)
				loader_pkg::LD_HEADER: begin
					if (byte_stb_i) begin
						hdr_cnt <= hdr_cnt + 1'b1;
						if (&hdr_cnt) begin // 16th byte arriving
							if (!hdr_ok) begin
								state   <= loader_pkg::LD_ERROR;
								error_o <= 1'b1;
								done_o  <= 1'b1;
							end else if (prg_bytes != '0) begin
								state      <= loader_pkg::LD_PRG;
								wr_addr    <= loader_pkg::PRG_BASE;
								bytes_left <= prg_bytes;
							end else if (chr_bytes != '0) begin
								state      <= loader_pkg::LD_CHR;
								wr_addr    <= loader_pkg::CHR_BASE;
								bytes_left <= chr_bytes;
							end else begin
								state <= loader_pkg::LD_DONE; // Empty image
							end
						end
					end
				end
				loader_pkg::LD_PRG, loader_pkg::LD_CHR: begin
					if (byte_stb_i) begin
						mem_write_o <= 1'b1;
						wr_addr     <= wr_addr + 1'b1;
						bytes_left  <= bytes_left - 1'b1;
						if (bytes_left == 1) begin
							// Last byte of this region
							if ((state == loader_pkg::LD_PRG) && (chr_bytes != '0)) begin
								state      <= loader_pkg::LD_CHR;
								wr_addr    <= loader_pkg::CHR_BASE;
								bytes_left <= chr_bytes;
							end else begin
								state <= loader_pkg::LD_DONE;
							end
						end
					end
				end
				loader_pkg::LD_DONE: begin
					done_o         <= 1'b1;
					mapper_flags_o <= flags; // Header fully captured by now
				end
				default: begin
					// LD_ERROR holds and trailing bytes are dropped
				end
			endcase
		end
	end

	// Writes only in a payload state or just after its last byte
	a_write_in_payload : assert property (@(posedge clk) disable iff (host_reset_loader)
		mem_write_o |-> in_payload ||
			((state == loader_pkg::LD_DONE) && $past(in_payload)));

endmodule

//--- source/ines_header_decode.sv
//--------------------------------------
// Combinational iNES header decode into
// the packed mapper flags
//--------------------------------------
`timescale 1ns/10ps

module ines_header_decode (
	input  loader_pkg::ines_fields_t  fields_i,
	output loader_pkg::mapper_flags_t flags_o
);

	logic is_nes20;
	logic is_dirty;

	// Smallest k with pages <= 2^k, saturating at 7
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd7;
		for (int k = 6; k >= 0; k--) begin
			if (pages <= (9'd1 << k))
				code = 3'(k);
		end
		return code;
	endfunction

	// Byte 7 bits 3:2 mark a 2.0 header
	assign is_nes20 = (fields_i.flags7[3:2] == 2'b10);

	// Junk in the tail of an old style header
	assign is_dirty = !is_nes20 &&
		((fields_i.byte9[7:1] != 7'd0) || (fields_i.tail != '0));

	always_comb begin
		flags_o             = '0;
		flags_o.nes20_ext   = is_nes20 ? fields_i.byte8 : 8'h00;
		flags_o.four_screen = fields_i.flags6[3];
		flags_o.chr_ram     = (fields_i.chr_pages == 8'd0); // No CHR ROM
		flags_o.mirroring   = fields_i.flags6[0];
		flags_o.chr_size    = size_code(fields_i.chr_pages);
		flags_o.prg_size    = size_code(fields_i.prg_pages);
		// Upper nibble dropped for dirty headers
		flags_o.mapper[7:4] = is_dirty ? 4'h0 : fields_i.flags7[7:4];
		flags_o.mapper[3:0] = fields_i.flags6[7:4];
	end

endmodule

//--- source/byte_pacer.sv
//--------------------------------------
// Unpacks buffered words into bytes,
// low byte first, one per BYTE_PERIOD
//--------------------------------------
`timescale 1ns/10ps

module byte_pacer (
	input  logic                          clk,
	input  logic                          host_reset_loader,
	input  logic [loader_pkg::WORD_W-1:0] word_i,
	input  logic                          empty_i,
	output logic                          pop_o,
	output logic [7:0]                    byte_o,
	output logic                          byte_stb_o
);

	logic [$clog2(loader_pkg::BYTE_PERIOD)-1:0] phase;    // Free running
	logic [$clog2(loader_pkg::WORD_W / 8)-1:0]  byte_idx; // Next byte of held word
	logic [loader_pkg::WORD_W-1:0]              held_word;
	logic                                       have_word;
	logic                                       phase_last;

	assign phase_last = (32'(phase) == loader_pkg::BYTE_PERIOD - 1);

	assign pop_o      = !have_word && !empty_i; // Refill once drained
	assign byte_stb_o = have_word && phase_last;
	assign byte_o     = held_word[byte_idx*8 +: 8];

	// Word holding register
	always_ff @(posedge clk) begin
		if (pop_o)
			held_word <= word_i;
	end

	always_ff @(posedge clk) begin
		if (host_reset_loader) begin
			phase     <= '0;
			byte_idx  <= '0;
			have_word <= 1'b0;
		end else begin
			phase <= phase_last ? '0 : phase + 1'b1;
			if (pop_o) begin
				have_word <= 1'b1;
				byte_idx  <= '0;
			end else if (byte_stb_o) begin
				byte_idx <= byte_idx + 1'b1;
				if (&byte_idx)
					have_word <= 1'b0; // Top byte gone
			end
		end
	end

endmodule

//--- source/word_fifo.sv
//--------------------------------------
// Single clock word FIFO between the
// host intake and the byte pacer
//--------------------------------------
`timescale 1ns/10ps

module word_fifo #(
	parameter int DEPTH = loader_pkg::FIFO_DEPTH
) (
	input  logic                          clk,
	input  logic                          host_reset_loader,
	input  logic                          push_i,
	input  logic [loader_pkg::WORD_W-1:0] word_i,
	input  logic                          pop_i,
	output logic [loader_pkg::WORD_W-1:0] word_o,
	output logic                          full_o,
	output logic                          empty_o
);

	logic [loader_pkg::WORD_W-1:0] mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]      wr_ptr;
	logic [$clog2(DEPTH)-1:0]      rd_ptr;
	logic [$clog2(DEPTH+1)-1:0]    count; // Fill level 0..DEPTH

	assign word_o  = mem[rd_ptr]; // Head word, no read latency
	assign full_o  = (32'(count) == DEPTH);
	assign empty_o = (count == '0);

	// Storage
	always_ff @(posedge clk) begin
		if (push_i)
			mem[wr_ptr] <= word_i;
	end

	// Pointers wrap at DEPTH so any depth works
	always_ff @(posedge clk) begin
		if (host_reset_loader) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i)
				wr_ptr <= (32'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (pop_i)
				rd_ptr <= (32'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			if (push_i && !pop_i)
				count <= count + 1'b1;
			else if (pop_i && !push_i)
				count <= count - 1'b1;
		end
	end

	a_no_overflow  : assert property (@(posedge clk) disable iff (host_reset_loader)
		full_o |-> !push_i);
	a_no_underflow : assert property (@(posedge clk) disable iff (host_reset_loader)
		empty_o |-> !pop_i);

endmodule

//--- source/boot_word_intake.sv
//--------------------------------------
// Host boot word handshake, one ack and
// one FIFO push per request
//--------------------------------------
`timescale 1ns/10ps

module boot_word_intake (
	input  logic                          clk,
	input  logic                          host_reset_loader,
	input  logic [loader_pkg::WORD_W-1:0] bootdata_i,
	input  logic                          bootdata_req_i,
	input  logic                          fifo_full_i,
	output logic                          bootdata_ack_o,
	output logic                          push_o,
	output logic [loader_pkg::WORD_W-1:0] push_word_o
);

	loader_pkg::boot_state_e state;

	// Accept only from idle with room in the buffer
	assign push_o      = (state == loader_pkg::BOOT_IDLE) && bootdata_req_i && !fifo_full_i;
	assign push_word_o = bootdata_i; // Host holds the word until ack

	always_ff @(posedge clk) begin
		if (host_reset_loader) begin
			state          <= loader_pkg::BOOT_IDLE;
			bootdata_ack_o <= 1'b0;
		end else begin
			bootdata_ack_o <= 1'b0; // Single cycle pulse
			case (state)
				loader_pkg::BOOT_IDLE: begin
					if (push_o) begin
						bootdata_ack_o <= 1'b1;
						state          <= loader_pkg::BOOT_ACK;
					end
				end
				default: begin
					// Host drops req while we sit here
					state <= loader_pkg::BOOT_IDLE;
				end
			endcase
		end
	end

	// Host must see a gap between acks
	a_ack_single : assert property (@(posedge clk) disable iff (host_reset_loader)
		bootdata_ack_o |=> !bootdata_ack_o);

endmodule

//--- source/loader_pkg.sv
//--------------------------------------
// Shared widths, states and record types
// for the iNES ROM loading path
//--------------------------------------
package loader_pkg;

	// Sizes
	localparam int ADDR_W         = 22;
	localparam int WORD_W         = 32;
	localparam int FIFO_DEPTH     = 8;  // Boot words buffered
	localparam int BYTE_PERIOD    = 4;  // Clocks per released byte
	localparam int PRG_PAGE_SHIFT = 14; // 16 KiB PRG pages
	localparam int CHR_PAGE_SHIFT = 13; // 8 KiB CHR pages

	localparam logic [ADDR_W-1:0] PRG_BASE = '0;
	localparam logic [ADDR_W-1:0] CHR_BASE = 22'h200000; // Top address bit set

	// Element 0 is the first byte of the file
	localparam logic [3:0][7:0] INES_MAGIC = {8'h1A, 8'h53, 8'h45, 8'h4E};

	//--------------------------------------
	// States
	//--------------------------------------
	typedef enum logic {BOOT_IDLE, BOOT_ACK} boot_state_e;

	typedef enum logic [2:0] {LD_HEADER, LD_PRG, LD_CHR, LD_DONE, LD_ERROR} load_state_e;

	//--------------------------------------
	// Records
	//--------------------------------------
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [7:0]        data;
	} mem_wr_t;

	// Header bytes 15 down to 4
	typedef struct packed {
		logic [5:0][7:0] tail;     // Bytes 15..10, tail[0] is byte 10
		logic [7:0]      byte9;
		logic [7:0]      byte8;    // iNES 2.0 mapper extension
		logic [7:0]      flags7;
		logic [7:0]      flags6;
		logic [7:0]      chr_pages;
		logic [7:0]      prg_pages;
	} ines_fields_t;

	typedef struct packed {
		logic [6:0] pad;
		logic [7:0] nes20_ext;
		logic       four_screen;
		logic       chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

endpackage
